/* edc_ctrl.f */
hdl/edc_pkg.sv
hdl/edc_scan_counter.sv
hdl/edc_window_decode.sv
hdl/edc_output_align.sv
hdl/edc_ctrl.sv
verification/edc_ctrl_ref_model.sv
verification/edc_ctrl_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the edc_ctrl testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module edc_ctrl_tb -f edc_ctrl.f -o edc_ctrl_sim \
    && ./obj_dir/edc_ctrl_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -q "Simulation finished: PASS" sim.log && echo "result: pass" \
    || { echo "result: fail"; exit 1; }

/* verification/edc_ctrl_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_ctrl_tb;

    localparam int N_FRAMES    = 4;
    localparam int FRAME_LEN   = edc_pkg::SLOT_COUNT * edc_pkg::CH_CYCLES;
    localparam int GAP_BITS    = 4;
    localparam int MAX_GAP     = (1 << GAP_BITS) - 1;
    localparam int CYCLE_LIMIT = N_FRAMES * (FRAME_LEN + 2) + N_FRAMES * MAX_GAP + 100;
    localparam int N_SHIFT     = edc_pkg::PAD_H * edc_pkg::PAD_W;
    localparam int N_PAD       = N_SHIFT - edc_pkg::MAP_H * edc_pkg::MAP_W;
    localparam int N_RESULT    = (edc_pkg::PAD_H - edc_pkg::FH + 1)
                               * (edc_pkg::PAD_W - edc_pkg::FW + 1);
    localparam int N_UPOOL     = edc_pkg::POOL_H * edc_pkg::POOL_W;

    logic clk;
    logic rst;
    logic start;
    logic                        busy;
    logic                        frame_done;
    logic                        fmap_in_shiftreg_en;
    logic                        pad_mux_sel;
    logic                        pe_en;
    logic                        w_rom_en;
    logic                        data_out_en;
    logic [edc_pkg::WADDR_W-1:0] w_rom_addr;
    logic [edc_pkg::UPOOL_W-1:0] upool_mux_sel;
    logic                        m_busy;
    logic                        m_frame_done;
    logic                        m_shift;
    logic                        m_pad;
    logic                        m_compute;
    logic                        m_data_out_en;
    logic [edc_pkg::WADDR_W-1:0] m_addr;
    logic [edc_pkg::UPOOL_W-1:0] m_upool;

    int          errors       = 0;
    int          cycles       = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic [31:0] lfsr_state   = 32'd81955;

    edc_ctrl u_edc_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .start               (start),
        .busy                (busy),
        .frame_done          (frame_done),
        .fmap_in_shiftreg_en (fmap_in_shiftreg_en),
        .pad_mux_sel         (pad_mux_sel),
        .pe_en               (pe_en),
        .w_rom_en            (w_rom_en),
        .w_rom_addr          (w_rom_addr),
        .upool_mux_sel       (upool_mux_sel),
        .data_out_en         (data_out_en)
    );

    edc_ctrl_ref_model u_ref_model (
        .clk             (clk),
        .rst             (rst),
        .start           (start),
        .exp_busy        (m_busy),
        .exp_frame_done  (m_frame_done),
        .exp_shift       (m_shift),
        .exp_pad         (m_pad),
        .exp_compute     (m_compute),
        .exp_addr        (m_addr),
        .exp_data_out_en (m_data_out_en),
        .exp_upool       (m_upool)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run still going after %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1 in Galois form
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value      = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic report_mismatch(input string name, input int dut, input int exp);
        errors++;
        $display("Fail %s: dut=%h exp=%h (cycle %0d)", name, dut, exp, cycles);
    endtask

    task automatic report_text(input string msg);
        errors++;
        $display("%s at cycle %0d", msg, cycles);
    endtask

    task automatic check_int(input string name, input int dut, input int exp);
        assert (dut == exp) else report_mismatch(name, dut, exp);
    endtask

    // cycle-by-cycle comparison against the model
    a_busy: assert property (@(posedge clk) disable iff (!rst) busy == m_busy)
        else report_text("busy level of the DUT differs from the model");
    a_done: assert property (@(posedge clk) disable iff (!rst) frame_done == m_frame_done)
        else report_mismatch("frame_done", int'($sampled(frame_done)),
                             int'($sampled(m_frame_done)));
    a_shift: assert property (@(posedge clk) disable iff (!rst) fmap_in_shiftreg_en == m_shift)
        else report_mismatch("fmap_in_shiftreg_en", int'($sampled(fmap_in_shiftreg_en)),
                             int'($sampled(m_shift)));
    a_pad: assert property (@(posedge clk) disable iff (!rst) pad_mux_sel == m_pad)
        else report_mismatch("pad_mux_sel", int'($sampled(pad_mux_sel)), int'($sampled(m_pad)));
    a_pe: assert property (@(posedge clk) disable iff (!rst) pe_en == m_compute)
        else report_mismatch("pe_en", int'($sampled(pe_en)), int'($sampled(m_compute)));
    a_rom: assert property (@(posedge clk) disable iff (!rst) w_rom_en == m_compute)
        else report_mismatch("w_rom_en", int'($sampled(w_rom_en)), int'($sampled(m_compute)));
    a_addr: assert property (@(posedge clk) disable iff (!rst) w_rom_addr == m_addr)
        else report_mismatch("w_rom_addr", int'($sampled(w_rom_addr)), int'($sampled(m_addr)));
    a_out: assert property (@(posedge clk) disable iff (!rst) data_out_en == m_data_out_en)
        else report_mismatch("data_out_en", int'($sampled(data_out_en)),
                             int'($sampled(m_data_out_en)));
    a_upool: assert property (@(posedge clk) disable iff (!rst) upool_mux_sel == m_upool)
        else report_mismatch("upool_mux_sel", int'($sampled(upool_mux_sel)),
                             int'($sampled(m_upool)));

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors != errors_before) begin
            tests_failed++;
        end
        $display("test %s: %0d errors", name, errors - errors_before);
    endtask

    task automatic run_frame(input string name, input int gap);
        int busy_cnt;
        int shift_cnt;
        int pad_cnt;
        int pe_cnt;
        int valid_cnt;
        int r;
        int errors_before;
        int hist [N_UPOOL];
        errors_before = errors;
        busy_cnt      = 0;
        shift_cnt     = 0;
        pad_cnt       = 0;
        pe_cnt        = 0;
        valid_cnt     = 0;
        foreach (hist[i]) begin
            hist[i] = 0;
        end
        repeat (gap) begin
            @(negedge clk);
            start = 1'b0;
        end
        @(negedge clk);
        start = 1'b1;
        do begin
            @(negedge clk);
            // stray start pulses while the scan runs
            take_bits(3, r);
            start = (r == 7);
            busy_cnt  += int'(busy);
            shift_cnt += int'(fmap_in_shiftreg_en);
            pad_cnt   += int'(pad_mux_sel);
            if (pe_en) begin
                check_int("w_rom_addr", int'(w_rom_addr), pe_cnt % edc_pkg::CH_CYCLES);
                pe_cnt++;
            end else begin
                check_int("w_rom_addr", int'(w_rom_addr), 0);
            end
            if (data_out_en) begin
                hist[upool_mux_sel]++;
                valid_cnt++;
            end
        end while (!frame_done);
        check_int("busy cycles", busy_cnt, FRAME_LEN);
        check_int("fmap_in_shiftreg_en pulses", shift_cnt, N_SHIFT);
        check_int("pad_mux_sel pulses", pad_cnt, N_PAD);
        check_int("pe_en cycles", pe_cnt, N_RESULT * edc_pkg::CH_CYCLES);
        check_int("data_out_en pulses", valid_cnt, N_RESULT);
        for (int i = 0; i < N_UPOOL; i++) begin
            check_int($sformatf("upool_mux_sel index %0d", i), hist[i], N_RESULT / N_UPOOL);
        end
        finish_test(name, errors_before);
    endtask

    initial begin
        int gap;
        int errors_before;
        start = 1'b0;
        rst   = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        errors_before = errors;
        repeat (3) begin
            @(negedge clk);
            check_int("all outputs", int'({busy, frame_done, fmap_in_shiftreg_en, pad_mux_sel,
                      pe_en, w_rom_en, w_rom_addr, upool_mux_sel, data_out_en}), 0);
        end
        finish_test("reset_state", errors_before);
        for (int f = 0; f < N_FRAMES; f++) begin
            // frame 1 follows frame 0 with no idle cycle
            if (f == 1) begin
                gap = 0;
            end else begin
                take_bits(GAP_BITS, gap);
            end
            run_frame($sformatf("frame_%0d_gap_%0d", f, gap), gap);
        end
        repeat (edc_pkg::ALIGN_DELAY + 2) begin
            @(negedge clk);
            start = 1'b0;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/edc_ctrl_ref_model.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_ctrl_ref_model (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic                        exp_busy,
    output logic                        exp_frame_done,
    output logic                        exp_shift,
    output logic                        exp_pad,
    output logic                        exp_compute,
    output logic [edc_pkg::WADDR_W-1:0] exp_addr,
    output logic                        exp_data_out_en,
    output logic [edc_pkg::UPOOL_W-1:0] exp_upool
);

    localparam int AW = edc_pkg::WADDR_W;
    localparam int UW = edc_pkg::UPOOL_W;
    localparam int AD = edc_pkg::ALIGN_DELAY;

    logic          scanning;
    int            slot;
    int            ch;
    int            row;
    int            col;
    logic          border;
    logic          in_compute;
    logic          slot_end;
    logic          exp_result_valid;
    logic [UW-1:0] held_upool;
    logic [AD-1:0] valid_sr;
    logic [UW-1:0] upool_sr [AD];

    // slot number unfolded into padded-map coordinates
    assign row        = slot / edc_pkg::PAD_W;
    assign col        = slot % edc_pkg::PAD_W;
    assign slot_end   = ch == edc_pkg::CH_CYCLES - 1;
    assign border     = row < edc_pkg::PAD || row >= edc_pkg::MAP_H + edc_pkg::PAD
                     || col < edc_pkg::PAD || col >= edc_pkg::MAP_W + edc_pkg::PAD;
    assign in_compute = scanning && row >= edc_pkg::FH - 1 && row < edc_pkg::PAD_H
                     && col >= edc_pkg::FW - 1;

    assign exp_busy       = scanning;
    assign exp_frame_done = scanning && slot_end && slot == edc_pkg::SLOT_COUNT - 1;

    always_ff @(posedge clk) begin
        if (!rst) begin
            scanning <= 1'b0;
            slot     <= 0;
            ch       <= 0;
        end else if (!scanning) begin
            scanning <= start;
            slot     <= 0;
            ch       <= 0;
        end else if (slot_end) begin
            ch       <= 0;
            slot     <= slot + 1;
            scanning <= !exp_frame_done;
        end else begin
            ch <= ch + 1;
        end
    end

    // decode stage one cycle behind the position
    always_ff @(posedge clk) begin
        if (!rst) begin
            exp_shift        <= 1'b0;
            exp_pad          <= 1'b0;
            exp_compute      <= 1'b0;
            exp_addr         <= '0;
            exp_result_valid <= 1'b0;
            held_upool       <= '0;
        end else begin
            exp_shift        <= scanning && ch == 0 && row < edc_pkg::PAD_H;
            exp_pad          <= scanning && ch == 0 && row < edc_pkg::PAD_H && border;
            exp_compute      <= in_compute;
            exp_addr         <= in_compute ? AW'(ch) : '0;
            exp_result_valid <= in_compute && slot_end;
            if (in_compute && slot_end) begin
                held_upool <= UW'(((row - (edc_pkg::FH - 1)) % 2) * 2
                                  + (col - (edc_pkg::FW - 1)) % 2);
            end
        end
    end

    // PE latency
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_sr <= '0;
            for (int i = 0; i < AD; i++) begin
                upool_sr[i] <= '0;
            end
        end else begin
            valid_sr    <= {valid_sr[AD-2:0], exp_result_valid};
            upool_sr[0] <= held_upool;
            for (int i = 1; i < AD; i++) begin
                upool_sr[i] <= upool_sr[i-1];
            end
        end
    end

    assign exp_data_out_en = valid_sr[AD-1];
    assign exp_upool       = upool_sr[AD-1];

endmodule

`default_nettype wire

/* hdl/edc_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,
    output logic                        busy,
    output logic                        frame_done,
    output logic                        fmap_in_shiftreg_en,
    output logic                        pad_mux_sel,
    output logic                        pe_en,
    output logic                        w_rom_en,
    output logic [edc_pkg::WADDR_W-1:0] w_rom_addr,
    output logic [edc_pkg::UPOOL_W-1:0] upool_mux_sel,
    output logic                        data_out_en
);

    edc_pkg::scan_pos_t scan_pos;
    edc_pkg::compute_t  compute;

    // scan -> decode -> align
    edc_scan_counter u_scan (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .pos        (scan_pos),
        .busy       (busy),
        .frame_done (frame_done)
    );

    edc_window_decode u_decode (
        .clk                 (clk),
        .rst                 (rst),
        .pos                 (scan_pos),
        .fmap_in_shiftreg_en (fmap_in_shiftreg_en),
        .pad_mux_sel         (pad_mux_sel),
        .pe_en               (pe_en),
        .w_rom_en            (w_rom_en),
        .w_rom_addr          (w_rom_addr),
        .result              (compute)
    );

    edc_output_align u_align (
        .clk           (clk),
        .rst           (rst),
        .result        (compute),
        .data_out_en   (data_out_en),
        .upool_mux_sel (upool_mux_sel)
    );

endmodule

`default_nettype wire

/* hdl/edc_output_align.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_output_align (
    input  logic                        clk,
    input  logic                        rst,
    input  edc_pkg::compute_t           result,
    output logic                        data_out_en,
    output logic [edc_pkg::UPOOL_W-1:0] upool_mux_sel
);

    // matches the PE pipeline depth
    edc_pkg::compute_t delay_q [edc_pkg::ALIGN_DELAY];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < edc_pkg::ALIGN_DELAY; i++) begin
                delay_q[i] <= '0;
            end
        end else begin
            delay_q[0] <= result;
            for (int i = 1; i < edc_pkg::ALIGN_DELAY; i++) begin
                delay_q[i] <= delay_q[i-1];
            end
        end
    end

    // oldest entry drives the output side
    assign data_out_en   = delay_q[edc_pkg::ALIGN_DELAY-1].result_valid;
    assign upool_mux_sel = delay_q[edc_pkg::ALIGN_DELAY-1].upool.index;

endmodule

`default_nettype wire

/* hdl/edc_window_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_window_decode (
    input  logic                        clk,
    input  logic                        rst,
    input  edc_pkg::scan_pos_t          pos,
    output logic                        fmap_in_shiftreg_en,
    output logic                        pad_mux_sel,
    output logic                        pe_en,
    output logic                        w_rom_en,
    output logic [edc_pkg::WADDR_W-1:0] w_rom_addr,
    output edc_pkg::compute_t           result
);

    int                  row_i;
    int                  col_i;
    int                  row_off;
    int                  col_off;
    logic                shift_hit;
    logic                border;
    logic                compute_hit;
    logic                result_hit;
    edc_pkg::upool_sel_u upool_next;

    assign row_i = int'(pos.row);
    assign col_i = int'(pos.col);

    // new input pixel enters once per slot outside the flush row
    assign shift_hit = pos.active && pos.ch == '0 && row_i < edc_pkg::PAD_H;

    assign border = row_i < edc_pkg::PAD
                 || row_i >= edc_pkg::MAP_H + edc_pkg::PAD
                 || col_i < edc_pkg::PAD
                 || col_i >= edc_pkg::MAP_W + edc_pkg::PAD;

    // full filter window ends at this pixel
    assign compute_hit = pos.active
                      && row_i >= edc_pkg::FH - 1 && row_i <= edc_pkg::PAD_H - 1
                      && col_i >= edc_pkg::FW - 1 && col_i <= edc_pkg::PAD_W - 1;

    assign result_hit = compute_hit && int'(pos.ch) == edc_pkg::CH_CYCLES - 1;

    assign row_off = row_i - (edc_pkg::FH - 1);
    assign col_off = col_i - (edc_pkg::FW - 1);

    // quadrant within the 2x2 unpool block
    always_comb begin
        upool_next.sub.sub_row = row_off[0];
        upool_next.sub.sub_col = col_off[0];
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            fmap_in_shiftreg_en <= 1'b0;
            pad_mux_sel         <= 1'b0;
            pe_en               <= 1'b0;
            w_rom_en            <= 1'b0;
            w_rom_addr          <= '0;
            result              <= '0;
        end else begin
            fmap_in_shiftreg_en <= shift_hit;
            pad_mux_sel         <= shift_hit && border;
            pe_en               <= compute_hit;
            w_rom_en            <= compute_hit;
            // one weight group per channel cycle
            w_rom_addr          <= compute_hit ? pos.ch : '0;
            result.result_valid <= result_hit;
            if (result_hit) begin
                result.upool <= upool_next;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/edc_scan_counter.sv */
`timescale 1ns/10ps
`default_nettype none

module edc_scan_counter (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    output edc_pkg::scan_pos_t pos,
    output logic               busy,
    output logic               frame_done
);

    logic                      state;
    logic [edc_pkg::ROW_W-1:0] row_cnt;
    logic [edc_pkg::COL_W-1:0] col_cnt;
    logic [edc_pkg::CH_W-1:0]  ch_cnt;
    logic                      ch_wrap;
    logic                      col_wrap;
    logic                      at_last_slot;
    logic                      last_cycle;

    assign ch_wrap  = int'(ch_cnt) == edc_pkg::CH_CYCLES - 1;
    assign col_wrap = int'(col_cnt) == edc_pkg::PAD_W - 1;

    // linear slot index of the current pixel
    assign at_last_slot = (int'(row_cnt) * edc_pkg::PAD_W + int'(col_cnt))
                          == edc_pkg::SLOT_COUNT - 1;

    assign busy       = state == edc_pkg::ST_SCAN;
    assign last_cycle = busy && ch_wrap && at_last_slot;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state   <= edc_pkg::ST_IDLE;
            row_cnt <= '0;
            col_cnt <= '0;
            ch_cnt  <= '0;
        end else if (state == edc_pkg::ST_IDLE) begin
            // start is only looked at here
            if (start) begin
                state <= edc_pkg::ST_SCAN;
            end
        end else begin
            if (ch_wrap) begin
                ch_cnt <= '0;
                if (col_wrap) begin
                    col_cnt <= '0;
                    row_cnt <= row_cnt + 1'b1;
                end else begin
                    col_cnt <= col_cnt + 1'b1;
                end
            end else begin
                ch_cnt <= ch_cnt + 1'b1;
            end
            if (last_cycle) begin
                state   <= edc_pkg::ST_IDLE;
                row_cnt <= '0;
            end
        end
    end

    always_comb begin
        pos.active    = busy;
        pos.row       = row_cnt;
        pos.col       = col_cnt;
        pos.ch        = ch_cnt;
        pos.last_slot = last_cycle;
    end

    assign frame_done = pos.last_slot;

endmodule

`default_nettype wire

/* hdl/edc_pkg.sv */
`default_nettype none

package edc_pkg;

    // feature map and filter geometry
    localparam int MAP_H     = 4;
    localparam int MAP_W     = 4;
    localparam int PAD       = 1;
    localparam int FH        = 3;
    localparam int FW        = 3;
    localparam int POOL_H    = 2;
    localparam int POOL_W    = 2;
    localparam int FD        = 8;
    localparam int N_PE      = 2;
    localparam int CH_CYCLES = FD / N_PE;

    // padded extents and the flush row below the map
    localparam int PAD_H       = MAP_H + 2 * PAD;
    localparam int PAD_W       = MAP_W + 2 * PAD;
    localparam int SCAN_ROWS   = PAD_H + 1;
    localparam int SLOT_COUNT  = SCAN_ROWS * PAD_W;
    localparam int ALIGN_DELAY = CH_CYCLES;

    localparam int ROW_W   = $clog2(SCAN_ROWS);
    localparam int COL_W   = $clog2(PAD_W);
    localparam int CH_W    = $clog2(CH_CYCLES);
    localparam int UPOOL_W = $clog2(POOL_H * POOL_W);
    localparam int WADDR_W = CH_W;

    localparam logic ST_IDLE = 1'b0;
    localparam logic ST_SCAN = 1'b1;

    typedef struct packed {
        logic             active;
        logic [ROW_W-1:0] row;
        logic [COL_W-1:0] col;
        logic [CH_W-1:0]  ch;
        logic             last_slot;
    } scan_pos_t;

    typedef struct packed {
        logic sub_row;
        logic sub_col;
    } upool_sub_t;

    // flat mux index or row/col quadrant of the unpooled output
    typedef union packed {
        logic [UPOOL_W-1:0] index;
        upool_sub_t         sub;
    } upool_sel_u;

    typedef struct packed {
        logic       result_valid;
        upool_sel_u upool;
    } compute_t;

endpackage

`default_nettype wire
